//--- verilog.f
+incdir+include
hdl/videoPkg.sv
hdl/gamePkg.sv
hdl/tileMapIf.sv
hdl/tileMap.sv
hdl/tankMotion.sv
hdl/pixelShader.sv
hdl/vgaDraw.sv
test/vgaDraw_chk.sv
test/vgaDrawTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= vgaDrawTb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/vgaDrawTb.sv
`timescale 1ns/1ps

module vgaDrawTb import videoPkg::*, gamePkg::*;
();

	// The map's include already set the guard
	`undef MAP_LAYOUT_SVH
	`include "mapLayout.svh"

	localparam int hRes = screenWidth;
	localparam int vRes = screenHeight;
	localparam int numSteps = 11;
	// Frame count that means run until the model takes a coin
	localparam int untilCoin = -1;
	localparam int frameLimit = 1000;
	localparam int watchdogNs = 100000;

	// Button bits: up, right, down, left
	localparam logic [3:0] btnNone = 4'b0000;
	localparam logic [3:0] btnRight = 4'b0100;
	localparam logic [3:0] btnDown = 4'b0010;

	typedef struct packed
	{
		logic [3:0] buttons;
		int frames;
		coordT probeX;
		coordT probeY;
		logic probeEna;
		pixelColourT expColour;
		coinT expCoin;
	} stepT;

	logic Master_Clock_In;
	logic rstN;
	logic dispEna;
	coordT pixelX;
	coordT pixelY;
	logic up;
	logic down;
	logic left;
	logic right;
	coinT coinValue;
	channelT red;
	channelT green;
	channelT blue;

	stepT steps [numSteps];
	string stepName [numSteps];
	int errors;
	int testsFailed;
	int testsRun;

	// Reference state of the game
	logic [3:0] modelTiles [mapRows][mapCols];
	int modelX;
	int modelY;
	coinT modelCoin;

	vgaDraw #(
		.hRes(hRes),
		.vRes(vRes)
	) u_dut
	(
		.Master_Clock_In(Master_Clock_In),
		.rstN(rstN),
		.dispEna(dispEna),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.up(up),
		.down(down),
		.left(left),
		.right(right),
		.coinValue(coinValue),
		.red(red),
		.green(green),
		.blue(blue)
	);

	initial
	begin
		Master_Clock_In = 1'b0;
		forever #5 Master_Clock_In = ~Master_Clock_In;
	end

	// Hard stop if the run stalls
	initial
	begin
		#(watchdogNs);
		$display("Simulation timed out after %0d ns", watchdogNs);
		$display("STATUS: FAIL");
		$finish;
	end

	//////////////////////////////
	// Reference model
	function automatic int tileCol(input int x);
		return (x >> tileShift) % mapCols;
	endfunction

	function automatic int tileRow(input int y);
		return (y >> tileShift) % mapRows;
	endfunction

	function automatic pixelColourT tileColour(input logic [3:0] code);
		case (code)
			4'd0: return emptyColour;
			4'd1: return solidColour;
			4'd2: return brickColour;
			4'd3: return coinColour;
			4'd4, 4'd5, 4'd6, 4'd7: return hazardColour;
			default: return unknownColour;
		endcase
	endfunction

	function automatic pixelColourT expectedColour(input int x, input int y, input logic ena);
		if (!ena)
			return blankColour;
		if ((x > hRes) || (y > vRes))
			return borderColour;
		// Tank box is inclusive on both edges
		if ((x >= modelX) && (x <= modelX + tankWidth) &&
			(y >= modelY) && (y <= modelY + tankWidth))
			return tankColour;
		return tileColour(modelTiles[tileRow(y)][tileCol(x)]);
	endfunction

	task automatic resetModel();
		for (int r = 0; r < mapRows; r++)
		begin
			for (int c = 0; c < mapCols; c++)
			begin
				modelTiles[r][c] = mapLayout[r][79 - 4 * c -: 4];
			end
		end
		modelX = tankStartPos;
		modelY = tankStartPos;
		modelCoin = '0;
	endtask

	// One frame update, exactly one action
	task automatic stepModel(input logic [3:0] buttons);
		int cx [4];
		int cy [4];
		logic [3:0] code [4];
		logic solid [4];
		int nx;
		int ny;
		bit wrapped;
		int coinAt;

		cx = '{modelX, modelX + tankWidth, modelX, modelX + tankWidth};
		cy = '{modelY, modelY, modelY + tankWidth, modelY + tankWidth};
		coinAt = -1;
		for (int i = 0; i < 4; i++)
		begin
			code[i] = modelTiles[tileRow(cy[i])][tileCol(cx[i])];
			solid[i] = (code[i] == 4'd1) || (code[i] == 4'd2);
			if ((coinAt < 0) && (code[i] == 4'd3))
				coinAt = i;
		end
		nx = modelX;
		ny = modelY;
		wrapped = 1'b0;
		if (modelY == edgeWidth)
		begin
			ny = vRes - tankWidth - 1;
			wrapped = 1'b1;
		end
		else if (modelY == vRes - tankWidth - edgeWidth)
		begin
			ny = 1;
			wrapped = 1'b1;
		end
		if (modelX == edgeWidth)
		begin
			nx = hRes - tankWidth - 1;
			wrapped = 1'b1;
		end
		else if (modelX == hRes - tankWidth - edgeWidth)
		begin
			nx = 1;
			wrapped = 1'b1;
		end
		if (!wrapped)
		begin
			// Push-back, pairs before single corners
			if (solid[2] && solid[3])
				ny--;
			else if (solid[0] && solid[2])
				nx++;
			else if (solid[0] && solid[1])
				ny++;
			else if (solid[1] && solid[3])
				nx--;
			else if (solid[0])
			begin
				nx++;
				ny++;
			end
			else if (solid[1])
			begin
				nx--;
				ny++;
			end
			else if (solid[2])
			begin
				nx++;
				ny--;
			end
			else if (solid[3])
			begin
				nx--;
				ny--;
			end
			else if (coinAt >= 0)
			begin
				modelTiles[tileRow(cy[coinAt])][tileCol(cx[coinAt])] = 4'd0;
				modelCoin = modelCoin + 8'd1;
			end
			else if (buttons[3])
				ny--;
			else if (buttons[2])
				nx++;
			else if (buttons[1])
				ny++;
			else if (buttons[0])
				nx--;
		end
		modelX = nx;
		modelY = ny;
	endtask

	//////////////////////////////
	// Drivers and checks
	task automatic driveButtons(input logic [3:0] buttons);
		up = buttons[3];
		right = buttons[2];
		down = buttons[1];
		left = buttons[0];
	endtask

	// Strobe pixel with buttons held, model steps on the same edge
	task automatic runFrame(input logic [3:0] buttons);
		dispEna = 1'b1;
		pixelX = coordT'(hRes);
		pixelY = coordT'(vRes);
		driveButtons(buttons);
		@(posedge Master_Clock_In);
		stepModel(buttons);
		#1;
	endtask

	// Colour is registered, read it one edge later
	task automatic probePixel(input coordT x, input coordT y, input logic ena,
		output pixelColourT got);
		dispEna = ena;
		pixelX = x;
		pixelY = y;
		driveButtons(btnNone);
		@(posedge Master_Clock_In);
		#1;
		got = pixelColourT'({red, green, blue});
	endtask

	task automatic checkColour(input pixelColourT got, input pixelColourT exp, input string what);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR at %0t ns: %s colour %03h, expected %03h", $time, what, got, exp);
		end
	endtask

	task automatic checkCoin(input coinT got, input coinT exp, input string what);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR at %0t ns: %s coinValue %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic reportTest(input string what, input int errBefore);
		testsRun++;
		if (errors != errBefore)
			testsFailed++;
		$display("Test %0d %s: %s", testsRun, what, (errors == errBefore) ? "passed" : "failed");
	endtask

	task automatic setStep(input int idx, input string what, input logic [3:0] buttons,
		input int frames, input int x, input int y, input logic ena,
		input pixelColourT colour, input int coin);
		stepName[idx] = what;
		steps[idx] = '{buttons, frames, coordT'(x), coordT'(y), ena, colour, coinT'(coin)};
	endtask

	task automatic fillTable();
		setStep(0, "tank after reset", btnNone, 0, 5, 5, 1'b1, tankColour, 0);
		setStep(1, "blanking", btnNone, 0, 5, 5, 1'b0, blankColour, 0);
		setStep(2, "border", btnNone, 0, 700, 10, 1'b1, borderColour, 0);
		setStep(3, "empty tile", btnNone, 0, 10, 470, 1'b1, emptyColour, 0);
		setStep(4, "brick tile", btnNone, 0, 40, 40, 1'b1, brickColour, 0);
		setStep(5, "coin tile", btnNone, 0, 70, 40, 1'b1, coinColour, 0);
		setStep(6, "move down", btnDown, 7, 10, 37, 1'b1, tankColour, 0);
		setStep(7, "below tank", btnNone, 0, 10, 38, 1'b1, emptyColour, 0);
		setStep(8, "coin pickup", btnRight, untilCoin, 100, 10, 1'b1, emptyColour, 1);
		setStep(9, "push-back tank", btnRight, 200, 191, 10, 1'b1, tankColour, 1);
		setStep(10, "solid block", btnNone, 0, 193, 10, 1'b1, solidColour, 1);
	endtask

	task automatic runStep(input int idx);
		int errBefore;
		int n;
		coinT startCoin;
		pixelColourT expColour;
		pixelColourT got;

		errBefore = errors;
		if (steps[idx].frames == untilCoin)
		begin
			startCoin = modelCoin;
			n = 0;
			// Bounded search for the pickup frame
			while ((modelCoin == startCoin) && (n < frameLimit))
			begin
				runFrame(steps[idx].buttons);
				n++;
			end
			if (modelCoin == startCoin)
			begin
				errors++;
				$display("No coin was picked up within %0d frames", frameLimit);
			end
		end
		else
		begin
			for (n = 0; n < steps[idx].frames; n++)
				runFrame(steps[idx].buttons);
		end
		expColour = expectedColour(steps[idx].probeX, steps[idx].probeY, steps[idx].probeEna);
		// Table values restate the behaviours, the model must agree
		if ((expColour !== steps[idx].expColour) || (modelCoin !== steps[idx].expCoin))
		begin
			errors++;
			$display("Reference model and test table disagree on %s", stepName[idx]);
		end
		probePixel(steps[idx].probeX, steps[idx].probeY, steps[idx].probeEna, got);
		checkColour(got, expColour, stepName[idx]);
		checkCoin(coinValue, modelCoin, stepName[idx]);
		reportTest(stepName[idx], errBefore);
	endtask

	//////////////////////////////
	// Main sequence
	initial
	begin
		errors = 0;
		testsFailed = 0;
		testsRun = 0;
		rstN = 1'b0;
		dispEna = 1'b0;
		pixelX = '0;
		pixelY = '0;
		driveButtons(btnNone);
		fillTable();
		resetModel();
		repeat (10) @(posedge Master_Clock_In);
		#1;
		rstN = 1'b1;

		// Outputs straight out of reset
		checkColour(pixelColourT'({red, green, blue}), blankColour, "reset");
		checkCoin(coinValue, 8'd0, "reset");
		reportTest("outputs after reset", 0);

		for (int i = 0; i < numSteps; i++)
			runStep(i);

		$display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- test/vgaDraw_chk.sv
`timescale 1ns/1ps

module vgaDraw_chk import videoPkg::*, gamePkg::*;
#(
	parameter int hRes = screenWidth,
	parameter int vRes = screenHeight
)
(
	input logic Master_Clock_In,
	input logic rstN,
	input logic dispEna,
	input coordT pixelX,
	input coordT pixelY,
	input logic clearEn,
	input coinT coinValue,
	input pixelColourT colour
);

	logic frameEnd;

	// Frame update pixel, decoded from the raster inputs
	assign frameEnd = dispEna && (pixelX == coordT'(hRes)) && (pixelY == coordT'(vRes));

	// Coin count moves only on the edge that sampled a frame update
	coinAfterStrobe: assert property (@(posedge Master_Clock_In) disable iff (!rstN)
		!$stable(coinValue) |-> $past(frameEnd))
		else $error("coinValue changed without a frame strobe");

	// Blanked pixel gives black one cycle later
	blankAfterIdle: assert property (@(posedge Master_Clock_In) disable iff (!rstN)
		!$past(dispEna) |-> (colour == blankColour))
		else $error("colour not black after dispEna was low");

	// Tile clears only ride on a frame update
	clearOnStrobe: assert property (@(posedge Master_Clock_In) disable iff (!rstN)
		clearEn |-> frameEnd)
		else $error("clearEn high outside a strobe cycle");

endmodule

//////////////////////////////
// Tank block and shader results, seen where they meet in the top level
bind vgaDraw vgaDraw_chk #(
	.hRes(hRes),
	.vRes(vRes)
) u_chk
(
	.Master_Clock_In(Master_Clock_In),
	.rstN(rstN),
	.dispEna(dispEna),
	.pixelX(pixelX),
	.pixelY(pixelY),
	.clearEn(mapBus.clearEn),
	.coinValue(coinValue),
	.colour(colour)
);

//--- hdl/vgaDraw.sv
`timescale 1ns/1ps

module vgaDraw import videoPkg::*, gamePkg::*;
#(
	parameter int hRes = screenWidth,
	parameter int vRes = screenHeight
)
(
	input logic Master_Clock_In,
	input logic rstN,
	input logic dispEna,
	input coordT pixelX,
	input coordT pixelY,
	input logic up,
	input logic down,
	input logic left,
	input logic right,
	output coinT coinValue,
	output channelT red,
	output channelT green,
	output channelT blue
);

	coordT tankX;
	coordT tankY;
	tileAddrT pixelAddr;
	tileCodeT pixelCode;
	pixelColourT colour;

	// Corner reads and tile clears
	tileMapIf mapBus ();

	//////////////////////////////
	// Blocks
	tileMap u_tileMap
	(
		.Master_Clock_In(Master_Clock_In),
		.rstN(rstN),
		.mapBus(mapBus.mapSide),
		.pixelAddr(pixelAddr),
		.pixelCode(pixelCode)
	);

	tankMotion #(
		.hRes(hRes),
		.vRes(vRes)
	) u_tankMotion
	(
		.Master_Clock_In(Master_Clock_In),
		.rstN(rstN),
		.dispEna(dispEna),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.up(up),
		.down(down),
		.left(left),
		.right(right),
		.mapBus(mapBus.tankSide),
		.tankX(tankX),
		.tankY(tankY),
		.coinValue(coinValue)
	);

	pixelShader #(
		.hRes(hRes),
		.vRes(vRes)
	) u_pixelShader
	(
		.Master_Clock_In(Master_Clock_In),
		.rstN(rstN),
		.dispEna(dispEna),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.tankX(tankX),
		.tankY(tankY),
		.pixelAddr(pixelAddr),
		.pixelCode(pixelCode),
		.colour(colour)
	);

	// Split the registered colour onto the pins
	assign red = colour.red;
	assign green = colour.green;
	assign blue = colour.blue;

endmodule

//--- hdl/pixelShader.sv
`timescale 1ns/1ps

module pixelShader import videoPkg::*, gamePkg::*;
#(
	parameter int hRes = screenWidth,
	parameter int vRes = screenHeight
)
(
	input logic Master_Clock_In,
	input logic rstN,
	input logic dispEna,
	input coordT pixelX,
	input coordT pixelY,
	input coordT tankX,
	input coordT tankY,
	output tileAddrT pixelAddr,
	input tileCodeT pixelCode,
	output pixelColourT colour
);

	logic inBorder;
	logic inTank;
	pixelColourT nextColour;

	// Flat colour per tile code
	function automatic pixelColourT paletteOf(input tileCodeT code);
		pixelColourT pick;
		case (4'(code))
			4'd0: pick = emptyColour;
			4'd1: pick = solidColour;
			4'd2: pick = brickColour;
			4'd3: pick = coinColour;
			4'd4, 4'd5, 4'd6, 4'd7: pick = hazardColour;
			default: pick = unknownColour;
		endcase
		return pick;
	endfunction

	// Tile under the current pixel
	assign pixelAddr = tileOf(pixelX, pixelY);

	// Outside the active raster
	assign inBorder = (pixelX > coordT'(hRes)) || (pixelY > coordT'(vRes));

	// Tank box, both edges inclusive
	assign inTank = (pixelX >= tankX) && (pixelX <= tankX + tankWidth) &&
		(pixelY >= tankY) && (pixelY <= tankY + tankWidth);

	//////////////////////////////
	// Colour select
	always_comb
	begin
		if (!dispEna)
			nextColour = blankColour;
		else if (inBorder)
			nextColour = borderColour;
		else if (inTank)
			nextColour = tankColour;
		else
			nextColour = paletteOf(pixelCode);
	end

	// One cycle latency to the output
	always_ff @(posedge Master_Clock_In or negedge rstN)
	begin
		if (!rstN)
			colour <= blankColour;
		else
			colour <= nextColour;
	end

endmodule

//--- hdl/tankMotion.sv
`timescale 1ns/1ps

module tankMotion import videoPkg::*, gamePkg::*;
#(
	parameter int hRes = screenWidth,
	parameter int vRes = screenHeight
)
(
	input logic Master_Clock_In,
	input logic rstN,
	input logic dispEna,
	input coordT pixelX,
	input coordT pixelY,
	input logic up,
	input logic down,
	input logic left,
	input logic right,
	tileMapIf.tankSide mapBus,
	output coordT tankX,
	output coordT tankY,
	output coinT coinValue
);

	// Wrap targets and trigger points
	localparam coordT edgeLow = coordT'(edgeWidth);
	localparam coordT xWrapEdge = coordT'(hRes - tankWidth - edgeWidth);
	localparam coordT yWrapEdge = coordT'(vRes - tankWidth - edgeWidth);
	localparam coordT xWrapTo = coordT'(hRes - tankWidth - 1);
	localparam coordT yWrapTo = coordT'(vRes - tankWidth - 1);

	logic strobe;
	coordT posX;
	coordT posY;
	dirT facing;
	coordT farX;
	coordT farY;
	logic [3:0] isSolid;
	logic [3:0] isCoin;
	logic takeCoin;
	logic [1:0] coinSel;
	coordT nextX;
	coordT nextY;
	dirT nextFacing;

	// One update per frame, on the last active pixel
	assign strobe = dispEna && (pixelX == coordT'(hRes)) && (pixelY == coordT'(vRes));

	//////////////////////////////
	// Corner look-ups
	assign farX = posX + coordT'(tankWidth);
	assign farY = posY + coordT'(tankWidth);

	assign mapBus.cornerAddr[0] = tileOf(posX, posY);
	assign mapBus.cornerAddr[1] = tileOf(farX, posY);
	assign mapBus.cornerAddr[2] = tileOf(posX, farY);
	assign mapBus.cornerAddr[3] = tileOf(farX, farY);

	always_comb
	begin
		for (int i = 0; i < 4; i++)
		begin
			// Solid block and brick both stop the tank
			isSolid[i] = (mapBus.cornerCode[i] == tileSolid) ||
				(mapBus.cornerCode[i] == tileBrick);
			isCoin[i] = (mapBus.cornerCode[i] == tileCoin);
		end
	end

	//////////////////////////////
	// Per-frame update, one action only
	always_comb
	begin
		nextX = posX;
		nextY = posY;
		nextFacing = facing;
		takeCoin = 1'b0;
		coinSel = 2'd0;

		// Wrap has top priority
		if ((posX == edgeLow) || (posX == xWrapEdge) ||
			(posY == edgeLow) || (posY == yWrapEdge))
		begin
			if (posY == edgeLow)
				nextY = yWrapTo;
			else if (posY == yWrapEdge)
				nextY = coordT'(1);
			if (posX == edgeLow)
				nextX = xWrapTo;
			else if (posX == xWrapEdge)
				nextX = coordT'(1);
		end
		// Edge pairs first
		else if (isSolid[2] && isSolid[3])
			nextY = posY - 1'b1;
		else if (isSolid[0] && isSolid[2])
			nextX = posX + 1'b1;
		else if (isSolid[0] && isSolid[1])
			nextY = posY + 1'b1;
		else if (isSolid[1] && isSolid[3])
			nextX = posX - 1'b1;
		// Then single corners, step away diagonally
		else if (isSolid[0])
		begin
			nextX = posX + 1'b1;
			nextY = posY + 1'b1;
		end
		else if (isSolid[1])
		begin
			nextX = posX - 1'b1;
			nextY = posY + 1'b1;
		end
		else if (isSolid[2])
		begin
			nextX = posX + 1'b1;
			nextY = posY - 1'b1;
		end
		else if (isSolid[3])
		begin
			nextX = posX - 1'b1;
			nextY = posY - 1'b1;
		end
		// Coin under a corner, first one in corner order
		else if (|isCoin)
		begin
			takeCoin = 1'b1;
			if (isCoin[0])
				coinSel = 2'd0;
			else if (isCoin[1])
				coinSel = 2'd1;
			else if (isCoin[2])
				coinSel = 2'd2;
			else
				coinSel = 2'd3;
		end
		// Buttons, up wins over right, down, left
		else if (up)
		begin
			nextY = posY - 1'b1;
			nextFacing = dirUp;
		end
		else if (right)
		begin
			nextX = posX + 1'b1;
			nextFacing = dirRight;
		end
		else if (down)
		begin
			nextY = posY + 1'b1;
			nextFacing = dirDown;
		end
		else if (left)
		begin
			nextX = posX - 1'b1;
			nextFacing = dirLeft;
		end
	end

	// Clear shares the strobe edge with the position update
	assign mapBus.clearEn = strobe && takeCoin;
	assign mapBus.clearAddr = mapBus.cornerAddr[coinSel];

	//////////////////////////////
	// State
	always_ff @(posedge Master_Clock_In or negedge rstN)
	begin
		if (!rstN)
		begin
			posX <= coordT'(tankStartPos);
			posY <= coordT'(tankStartPos);
			facing <= dirUp;
			coinValue <= '0;
		end
		else if (strobe)
		begin
			posX <= nextX;
			posY <= nextY;
			facing <= nextFacing;
			// Counter rolls over at 255
			if (takeCoin)
				coinValue <= coinValue + 1'b1;
		end
	end

	assign tankX = posX;
	assign tankY = posY;

endmodule

//--- hdl/tileMap.sv
`timescale 1ns/1ps

module tileMap import gamePkg::*;
(
	input logic Master_Clock_In,
	input logic rstN,
	tileMapIf.mapSide mapBus,
	input tileAddrT pixelAddr,
	output tileCodeT pixelCode
);

	`include "mapLayout.svh"

	// 20x15 tile codes, kept in flops for the five parallel reads
	tileCodeT tiles [mapRows][mapCols];

	//////////////////////////////
	// Storage and clear port
	always_ff @(posedge Master_Clock_In or negedge rstN)
	begin
		if (!rstN)
		begin
			// Load the fixed layout, one nibble per column
			for (int r = 0; r < mapRows; r++)
			begin
				for (int c = 0; c < mapCols; c++)
				begin
					tiles[r][c] <= tileCodeT'(mapLayout[r][79 - 4 * c -: 4]);
				end
			end
		end
		else if (mapBus.clearEn)
		begin
			// Whole code goes to empty
			tiles[mapBus.clearAddr.row][mapBus.clearAddr.col] <= tileEmpty;
		end
	end

	//////////////////////////////
	// Read ports
	// Pixel read for the shader
	assign pixelCode = tiles[pixelAddr.row][pixelAddr.col];

	// Four corner reads for the tank block
	always_comb
	begin
		for (int i = 0; i < 4; i++)
		begin
			mapBus.cornerCode[i] = tiles[mapBus.cornerAddr[i].row][mapBus.cornerAddr[i].col];
		end
	end

endmodule

//--- hdl/tileMapIf.sv
`timescale 1ns/1ps

interface tileMapIf import gamePkg::*; ();

	// Corner order: top-left, top-right, bottom-left, bottom-right
	tileAddrT cornerAddr [4];
	// Codes come back in the same cycle
	tileCodeT cornerCode [4];

	// Single cycle clear request, lands on the sampling edge
	logic clearEn;
	tileAddrT clearAddr;

	modport mapSide
	(
		input cornerAddr,
		input clearEn,
		input clearAddr,
		output cornerCode
	);

	modport tankSide
	(
		output cornerAddr,
		output clearEn,
		output clearAddr,
		input cornerCode
	);

endinterface

//--- hdl/gamePkg.sv
package gamePkg;

	// Map size in tiles
	localparam int mapCols = 20;
	localparam int mapRows = 15;

	// 32 pixel tiles
	localparam int tileShift = 5;

	typedef enum logic [3:0]
	{
		tileEmpty = 4'd0,
		tileSolid = 4'd1,
		tileBrick = 4'd2,
		tileCoin = 4'd3
	} tileCodeT;

	typedef logic [4:0] colIdxT;
	typedef logic [3:0] rowIdxT;

	typedef struct packed
	{
		rowIdxT row;
		colIdxT col;
	} tileAddrT;

	// Facing of the tank
	typedef enum logic [1:0]
	{
		dirUp = 2'd0,
		dirDown = 2'd1,
		dirLeft = 2'd2,
		dirRight = 2'd3
	} dirT;

	//////////////////////////////
	// Tank geometry
	localparam int tankWidth = 25;
	localparam int edgeWidth = 0;
	localparam int tankStartPos = 5;

	typedef logic [7:0] coinT;

	// Pixel coordinate to tile, the tile index wraps with the map size
	function automatic tileAddrT tileOf(input logic [9:0] x, input logic [9:0] y);
		tileAddrT addr;
		addr.col = colIdxT'((x >> tileShift) % mapCols);
		addr.row = rowIdxT'((y >> tileShift) % mapRows);
		return addr;
	endfunction

endpackage

//--- hdl/videoPkg.sv
package videoPkg;

	// Active raster size in pixels
	localparam int screenWidth = 640;
	localparam int screenHeight = 480;

	// Raster coordinate, wide enough for 1023
	typedef logic [9:0] coordT;

	typedef logic [3:0] channelT;

	// 12-bit pixel colour, red in the top nibble
	typedef struct packed
	{
		channelT red;
		channelT green;
		channelT blue;
	} pixelColourT;

	//////////////////////////////
	// Palette
	localparam pixelColourT blankColour = 12'h000;
	localparam pixelColourT borderColour = 12'h222;
	localparam pixelColourT emptyColour = 12'hEEE;
	localparam pixelColourT solidColour = 12'h777;
	localparam pixelColourT brickColour = 12'hB42;
	localparam pixelColourT coinColour = 12'hFD0;
	// Shared by tile codes 4 to 7
	localparam pixelColourT hazardColour = 12'hF44;
	localparam pixelColourT unknownColour = 12'h888;
	localparam pixelColourT tankColour = 12'h2A4;

endpackage

//--- include/mapLayout.svh
`ifndef MAP_LAYOUT_SVH
`define MAP_LAYOUT_SVH

// Reset layout, one nibble per tile, column 0 in the top nibble
// Codes: 0 empty, 1 solid, 2 brick, 3 coin
localparam logic [79:0] mapLayout [0:14] = '{
	80'h0003_0010_0000_0000_0000,
	80'h0232_3223_2332_3223_2320,
	80'h0332_3333_2332_3333_2330,
	80'h0222_2223_2332_3222_2220,
	80'h0332_3333_2332_3333_2330,
	80'h0232_3223_2222_3223_2330,
	80'h0333_3333_3333_3333_3330,
	80'h0222_2232_2222_2322_2220,
	80'h0333_3333_3333_3333_3330,
	80'h0232_3223_2222_3223_2320,
	80'h0332_3333_2332_3333_2330,
	80'h0222_2223_2332_3222_2220,
	80'h0332_3333_2332_3333_2330,
	80'h0232_3223_2332_3223_2320,
	80'h0000_0000_0000_0000_0000
};

`endif
